// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rvc_front_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+source
source/rvc_pkg.sv
source/skid_buffer.sv
source/rvc_expander.sv
source/decode_decompress.sv
source/rvc_front_top.sv
dv/rvc_front_props.sv
dv/rvc_front_tb.sv

// ==== dv/rvc_front_props.sv ====
`timescale 1ns/1ps

module rvc_front_props (
    input logic            clk,
    input logic            rst_n,
    input logic            flush,
    input logic            out_stalled,
    input logic            out_valid_n,
    input logic            out_exception,
    input logic [3:0]      out_trap_cause,
    input rvc_pkg::instr_t out_original,
    input rvc_pkg::instr_t out_expanded,
    input rvc_pkg::addr_t  out_addr,
    input rvc_pkg::addr_t  out_next_addr
);

    assert property (@(posedge clk) !rst_n |=> out_valid_n)
        else $error("output valid right after reset");

    // A stalled item stays put until taken
    assert property (@(posedge clk) disable iff (!rst_n)
        (!out_valid_n && out_stalled && !flush) |=>
        (flush || (!out_valid_n && $stable(out_exception) && $stable(out_trap_cause)
         && $stable(out_original) && $stable(out_expanded) && $stable(out_addr)
         && $stable(out_next_addr))))
        else $error("stalled output changed");

    assert property (@(posedge clk) disable iff (!rst_n)
        (!out_valid_n && !out_exception) |-> out_expanded[1:0] == 2'b11)
        else $error("expanded word is not a 32-bit encoding");

endmodule

bind rvc_front_top rvc_front_props u_props (
    .clk(clk), .rst_n(rst_n), .flush(flush), .out_stalled(out_stalled),
    .out_valid_n(out_valid_n), .out_exception(out_exception),
    .out_trap_cause(out_trap_cause), .out_original(out_original),
    .out_expanded(out_expanded), .out_addr(out_addr),
    .out_next_addr(out_next_addr)
);

// ==== dv/rvc_front_tb.sv ====
`timescale 1ns/1ps

module rvc_front_tb;

    logic                 clk;
    logic                 rst_n;
    logic                 flush;
    logic                 prev_stalled;
    logic                 stall_prev;
    logic                 ifetch_exception;
    rvc_pkg::trap_cause_e ifetch_trap_cause;
    rvc_pkg::instr_t      instruction;
    rvc_pkg::addr_t       instruction_addr;
    rvc_pkg::addr_t       instruction_next_addr;
    logic                 out_stalled;
    logic                 out_valid_n;
    logic                 out_exception;
    rvc_pkg::trap_cause_e out_trap_cause;
    rvc_pkg::instr_t      out_original;
    rvc_pkg::instr_t      out_expanded;
    rvc_pkg::addr_t       out_addr;
    rvc_pkg::addr_t       out_next_addr;

    // Stimulus table, one row per instruction
    rvc_pkg::instr_t      tab_instr[$];
    logic                 tab_fexc[$];
    rvc_pkg::trap_cause_e tab_fcause[$];
    rvc_pkg::instr_t      tab_exp[$];
    logic                 tab_eexc[$];
    rvc_pkg::trap_cause_e tab_ecause[$];

    int             sb_idx[$];  // Scoreboard of accepted items
    rvc_pkg::addr_t sb_addr[$];
    int             sb_cycle[$];

    int             seed = 85;
    int             errors = 0;
    int             checks = 0;
    int             cycle = 0;
    int             item_no = 0;
    int             cur_idx = 0;
    int             stall_mode = 0;  // 0 none, 1 random, 2 held
    bit             stall_draw = 0;  // Next out_stalled value
    bit             check_latency = 0;

    rvc_front_top dut0 (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .prev_stalled(prev_stalled), .stall_prev(stall_prev),
        .ifetch_exception(ifetch_exception), .ifetch_trap_cause(ifetch_trap_cause),
        .instruction(instruction), .instruction_addr(instruction_addr),
        .instruction_next_addr(instruction_next_addr),
        .out_stalled(out_stalled), .out_valid_n(out_valid_n),
        .out_exception(out_exception), .out_trap_cause(out_trap_cause),
        .out_original(out_original), .out_expanded(out_expanded),
        .out_addr(out_addr), .out_next_addr(out_next_addr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task add_row(input rvc_pkg::instr_t i, input logic fe, input rvc_pkg::trap_cause_e fc,
                 input rvc_pkg::instr_t e, input logic ee, input rvc_pkg::trap_cause_e ec);
        tab_instr.push_back(i);
        tab_fexc.push_back(fe);
        tab_fcause.push_back(fc);
        tab_exp.push_back(e);
        tab_eexc.push_back(ee);
        tab_ecause.push_back(ec);
    endtask

    task load_table;
        rvc_pkg::trap_cause_e none;
        rvc_pkg::trap_cause_e ill;
        none = rvc_pkg::EXC_INSTR_MISALIGNED;  // Cause field is zero without an exception
        ill  = rvc_pkg::EXC_ILLEGAL_INSTR;
        add_row(32'h0000_0085, 0, none, 32'h0010_8093, 0, none);  // c.addi x1, 1
        add_row(32'h0000_557d, 0, none, 32'hfff0_0513, 0, none);  // c.li x10, -1
        add_row(32'h0000_852e, 0, none, 32'h00b0_0533, 0, none);  // c.mv x10, x11
        add_row(32'h0000_952e, 0, none, 32'h00b5_0533, 0, none);  // c.add
        add_row(32'h0000_8082, 0, none, 32'h0000_8067, 0, none);  // c.jr x1
        add_row(32'h0000_4044, 0, none, 32'h0044_2483, 0, none);  // c.lw x9, 4(x8)
        add_row(32'h0000_0001, 0, none, 32'h0000_0013, 0, none);  // c.nop
        add_row(32'h0000_9002, 0, none, 32'h0010_0073, 0, none);  // c.ebreak
        add_row(32'h00a5_0533, 0, none, 32'h00a5_0533, 0, none);
        add_row(32'hfff0_0513, 0, none, 32'hfff0_0513, 0, none);
        add_row(32'h0000_0000, 0, none, 32'h0000_0000, 1, ill);
        add_row(32'h0000_2000, 0, none, 32'h0000_0000, 1, ill);   // c.fld
        add_row(32'h0000_6081, 0, none, 32'h0000_0000, 1, ill);   // c.lui, zero imm
        add_row(32'h0000_9c41, 0, none, 32'h0000_0000, 1, ill);   // Reserved ALU op
        add_row(32'h0000_8002, 0, none, 32'h0000_0000, 1, ill);   // c.jr x0
        add_row(32'h0000_0000, 1, rvc_pkg::EXC_INSTR_PAGE_FAULT, 32'h0000_0000, 1,
                rvc_pkg::EXC_INSTR_PAGE_FAULT);
        add_row(32'h0000_0085, 1, rvc_pkg::EXC_INSTR_ACCESS, 32'h0010_8093, 1,
                rvc_pkg::EXC_INSTR_ACCESS);
    endtask

    function automatic rvc_pkg::addr_t step_of(input rvc_pkg::instr_t i);
        return (i[1:0] == 2'b11) ? 64'd4 : 64'd2;
    endfunction

    task check_instr(input rvc_pkg::instr_t got, input rvc_pkg::instr_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task check_addr(input rvc_pkg::addr_t got, input rvc_pkg::addr_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task check_cause(input rvc_pkg::trap_cause_e got, input rvc_pkg::trap_cause_e exp,
                     input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task check_output;
        int             idx;
        int             c0;
        rvc_pkg::addr_t a;
        if (sb_idx.size() == 0) begin
            errors++;
            $display("At %0t the DUT sent an item that was never accepted", $time);
        end else begin
            idx = sb_idx.pop_front();
            a   = sb_addr.pop_front();
            c0  = sb_cycle.pop_front();
            check_instr(out_original, tab_instr[idx], "original");
            check_instr(out_expanded, tab_exp[idx], "expanded");
            check_flag(out_exception, tab_eexc[idx], "exception");
            check_cause(out_trap_cause, tab_ecause[idx], "cause");
            check_addr(out_addr, a, "addr");
            check_addr(out_next_addr, a + step_of(tab_instr[idx]), "next_addr");
            if (check_latency && cycle - c0 != 1) begin
                errors++;
                $display("MISMATCH at %0t: latency %0d cycles, expected 1", $time, cycle - c0);
            end
        end
    endtask

    // Handshake monitor
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (rst_n && flush) begin
            sb_idx.delete();
            sb_addr.delete();
            sb_cycle.delete();
        end else if (rst_n) begin
            if (!out_valid_n && !out_stalled)
                check_output();
            if (!prev_stalled && !stall_prev) begin
                sb_idx.push_back(cur_idx);
                sb_addr.push_back(instruction_addr);
                sb_cycle.push_back(cycle);
            end
        end
    end

    always @(posedge clk) begin
        if (stall_mode == 1)
            stall_draw = ($random(seed) % 2) != 0;
        else
            stall_draw = (stall_mode == 2);
    end

    always @(negedge clk) begin
        out_stalled = stall_draw;
    end

    task drive_item(input int idx, input bit rnd);
        if (rnd) begin
            while (($random(seed) % 3) == 0) begin
                prev_stalled = 1'b1;
                @(negedge clk);
            end
        end
        cur_idx               = idx;
        ifetch_exception      = tab_fexc[idx];
        ifetch_trap_cause     = tab_fcause[idx];
        instruction           = tab_instr[idx];
        instruction_addr      = 64'(item_no) * 64'd2;
        instruction_next_addr = instruction_addr + step_of(tab_instr[idx]);
        prev_stalled          = 1'b0;
        item_no++;
        @(posedge clk);
        while (stall_prev)
            @(posedge clk);
        @(negedge clk);
    endtask

    task wait_drained;
        prev_stalled = 1'b1;
        while (sb_idx.size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    task report_phase(input string name, input int err_before);
        $display("%s: %0d errors", name, errors - err_before);
    endtask

    // Watchdog
    initial begin
        #1;
        repeat (tab_instr.size() * 40) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", tab_instr.size() * 40);
        $display("test failed");
        $finish;
    end

    initial begin
        int e0;
        rst_n = 1'b0;
        flush = 1'b0;
        prev_stalled = 1'b1;
        out_stalled = 1'b0;
        ifetch_exception = 1'b0;
        ifetch_trap_cause = rvc_pkg::EXC_INSTR_MISALIGNED;
        instruction = '0;
        instruction_addr = '0;
        instruction_next_addr = '0;
        load_table();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        e0 = errors;
        check_latency = 1;
        for (int i = 0; i < tab_instr.size(); i++)
            drive_item(i, 0);
        wait_drained();
        check_latency = 0;
        report_phase("table, no stalls", e0);

        e0 = errors;
        stall_mode = 1;
        for (int r = 0; r < 2; r++)
            for (int i = 0; i < tab_instr.size(); i++)
                drive_item(i, 1);
        stall_mode = 0;
        wait_drained();
        report_phase("table, random stalls", e0);

        e0 = errors;
        stall_mode = 2;  // Fill the pipe, then drop its contents
        @(negedge clk);
        for (int i = 0; i < 3; i++)
            drive_item(i, 0);
        prev_stalled = 1'b1;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        stall_mode = 0;
        @(negedge clk);
        drive_item(5, 0);
        wait_drained();
        report_phase("flush", e0);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== source/decode_decompress.sv ====
`timescale 1ns/1ps

module decode_decompress (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,

    input  logic                 prev_stalled,
    input  logic                 next_stalled,
    output logic                 stall_prev,
    output logic                 stall_next,

    input  logic                 ifetch_exception,
    input  rvc_pkg::trap_cause_e ifetch_trap_cause,
    input  rvc_pkg::instr_t      instruction,
    input  rvc_pkg::addr_t       instruction_addr,
    input  rvc_pkg::addr_t       instruction_next_addr,

    output logic                 decomp_exception,
    output rvc_pkg::trap_cause_e decomp_trap_cause,
    output rvc_pkg::instr_t      decomp_original_instruction,
    output rvc_pkg::instr_t      decomp_expanded_instruction,
    output rvc_pkg::addr_t       decomp_instruction_addr,
    output rvc_pkg::addr_t       decomp_instruction_next_addr
);

    rvc_pkg::fetch_entry_t fetch_in;
    rvc_pkg::fetch_entry_t fetch_q;
    logic                  fetch_empty;
    logic                  reg_valid;
    logic                  load_en;
    rvc_pkg::instr_t       expanded;
    logic                  illegal;
    logic                  exc;
    rvc_pkg::trap_cause_e  cause;

    assign fetch_in.exception   = ifetch_exception;
    assign fetch_in.cause       = ifetch_trap_cause;
    assign fetch_in.instruction = instruction;
    assign fetch_in.addr        = instruction_addr;
    assign fetch_in.next_addr   = instruction_next_addr;

    skid_buffer #(
        .payload_t (rvc_pkg::fetch_entry_t)
    ) u_in_skid (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .prev_stalled (prev_stalled),
        .next_stalled (!load_en),
        .stall_prev   (stall_prev),
        .stall_next   (fetch_empty),
        .in_data      (fetch_in),
        .out_data     (fetch_q)
    );

    rvc_expander u_expander (
        .instruction (fetch_q.instruction),
        .expanded    (expanded),
        .illegal     (illegal)
    );

    // Fetch fault wins over a bad encoding
    always_comb begin
        if (fetch_q.exception) begin
            exc   = 1'b1;
            cause = fetch_q.cause;
        end else if (illegal) begin
            exc   = 1'b1;
            cause = rvc_pkg::EXC_ILLEGAL_INSTR;
        end else begin
            exc   = 1'b0;
            cause = rvc_pkg::trap_cause_e'(4'd0);
        end
    end

    assign load_en = !reg_valid || !next_stalled;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            reg_valid <= 1'b0;
        end else if (load_en) begin
            reg_valid <= !fetch_empty;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en && !fetch_empty) begin
            decomp_exception             <= exc;
            decomp_trap_cause            <= cause;
            decomp_original_instruction  <= fetch_q.instruction;
            decomp_expanded_instruction  <= expanded;
            decomp_instruction_addr      <= fetch_q.addr;
            decomp_instruction_next_addr <= fetch_q.next_addr;
        end
    end

    assign stall_next = !reg_valid;

endmodule

// ==== source/rvc_defines.svh ====
`ifndef RVC_DEFINES_SVH
`define RVC_DEFINES_SVH

// Widths shared by the front end

`define RVC_ILEN 32  // Expanded instruction word
`define RVC_ALEN 64  // Virtual address

`endif

// ==== source/rvc_expander.sv ====
`timescale 1ns/1ps

module rvc_expander (
    input  rvc_pkg::instr_t instruction,
    output rvc_pkg::instr_t expanded,
    output logic            illegal
);

    logic [15:0]     c;
    rvc_pkg::c_op_e  c_op;
    logic            is_rvc;

    logic [5:0]      ci_imm;
    logic [9:0]      a16_imm;   // ADDI16SP
    logic [7:0]      lwsp_off;
    logic [8:0]      ldsp_off;
    logic [7:0]      swsp_off;
    logic [8:0]      sdsp_off;
    logic [9:0]      ciw_imm;
    logic [6:0]      lw_off;
    logic [7:0]      ld_off;
    logic [11:0]     cj_off;
    logic [8:0]      cb_off;
    logic [4:0]      rd;
    logic [4:0]      rs2;
    logic [4:0]      rs1_p;     // Also rd' of CB and CA forms
    logic [4:0]      rs2_p;     // Also rd' of CIW and CL forms
    rvc_pkg::instr_t exp_c;
    logic            rsvd;

    assign c      = instruction[15:0];
    assign c_op   = rvc_pkg::c_op_e'({c[15:13], c[1:0]});
    assign is_rvc = c[1:0] != 2'b11;

    assign ci_imm   = {c[12], c[6:2]};
    assign a16_imm  = {c[12], c[4:3], c[5], c[2], c[6], 4'b0000};
    assign lwsp_off = {c[3:2], c[12], c[6:4], 2'b00};
    assign ldsp_off = {c[4:2], c[12], c[6:5], 3'b000};
    assign swsp_off = {c[8:7], c[12:9], 2'b00};
    assign sdsp_off = {c[9:7], c[12:10], 3'b000};
    assign ciw_imm  = {c[10:7], c[12:11], c[5], c[6], 2'b00};
    assign lw_off   = {c[5], c[12:10], c[6], 2'b00};
    assign ld_off   = {c[6:5], c[12:10], 3'b000};
    assign cj_off   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    assign cb_off   = {c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};

    assign rd    = c[11:7];
    assign rs2   = c[6:2];
    assign rs1_p = {2'b01, c[9:7]};
    assign rs2_p = {2'b01, c[4:2]};

    always_comb begin
        exp_c = '0;
        rsvd  = 1'b0;
        case (c_op)
            rvc_pkg::C_ADDI4SPN: begin
                exp_c = {2'b00, ciw_imm, 5'd2, 3'b000, rs2_p, rvc_pkg::OP_IMM, 2'b11};
                rsvd  = ciw_imm == '0;  // Covers the all-zero word
            end
            rvc_pkg::C_LW:
                exp_c = {5'b0, lw_off, rs1_p, 3'b010, rs2_p, rvc_pkg::LOAD, 2'b11};
            rvc_pkg::C_LD:
                exp_c = {4'b0, ld_off, rs1_p, 3'b011, rs2_p, rvc_pkg::LOAD, 2'b11};
            rvc_pkg::C_SW:
                exp_c = {5'b0, lw_off[6:5], rs2_p, rs1_p, 3'b010, lw_off[4:0],
                         rvc_pkg::STORE, 2'b11};
            rvc_pkg::C_SD:
                exp_c = {4'b0, ld_off[7:5], rs2_p, rs1_p, 3'b011, ld_off[4:0],
                         rvc_pkg::STORE, 2'b11};
            rvc_pkg::C_ADDI:
                exp_c = {{6{ci_imm[5]}}, ci_imm, rd, 3'b000, rd, rvc_pkg::OP_IMM, 2'b11};
            rvc_pkg::C_ADDIW: begin
                exp_c = {{6{ci_imm[5]}}, ci_imm, rd, 3'b000, rd, rvc_pkg::OP_IMM_32, 2'b11};
                rsvd  = rd == '0;
            end
            rvc_pkg::C_LI:
                exp_c = {{6{ci_imm[5]}}, ci_imm, 5'd0, 3'b000, rd, rvc_pkg::OP_IMM, 2'b11};
            rvc_pkg::C_LUI_ADDI16SP: begin
                if (rd == 5'd2) begin
                    exp_c = {{2{a16_imm[9]}}, a16_imm, 5'd2, 3'b000, 5'd2,
                             rvc_pkg::OP_IMM, 2'b11};
                end else begin
                    exp_c = {{14{ci_imm[5]}}, ci_imm, rd, rvc_pkg::LUI, 2'b11};
                end
                rsvd = ci_imm == '0;
            end
            rvc_pkg::C_MISC_ALU: begin
                case (c[11:10])
                    2'b00: exp_c = {6'b000000, ci_imm, rs1_p, 3'b101, rs1_p,
                                    rvc_pkg::OP_IMM, 2'b11};  // SRLI
                    2'b01: exp_c = {6'b010000, ci_imm, rs1_p, 3'b101, rs1_p,
                                    rvc_pkg::OP_IMM, 2'b11};  // SRAI
                    2'b10: exp_c = {{6{ci_imm[5]}}, ci_imm, rs1_p, 3'b111, rs1_p,
                                    rvc_pkg::OP_IMM, 2'b11};  // ANDI
                    default: begin
                        case ({c[12], c[6:5]})
                            3'b000: exp_c = {7'b0100000, rs2_p, rs1_p, 3'b000, rs1_p,
                                             rvc_pkg::OP, 2'b11};     // SUB
                            3'b001: exp_c = {7'b0, rs2_p, rs1_p, 3'b100, rs1_p,
                                             rvc_pkg::OP, 2'b11};     // XOR
                            3'b010: exp_c = {7'b0, rs2_p, rs1_p, 3'b110, rs1_p,
                                             rvc_pkg::OP, 2'b11};     // OR
                            3'b011: exp_c = {7'b0, rs2_p, rs1_p, 3'b111, rs1_p,
                                             rvc_pkg::OP, 2'b11};     // AND
                            3'b100: exp_c = {7'b0100000, rs2_p, rs1_p, 3'b000, rs1_p,
                                             rvc_pkg::OP_32, 2'b11};  // SUBW
                            3'b101: exp_c = {7'b0, rs2_p, rs1_p, 3'b000, rs1_p,
                                             rvc_pkg::OP_32, 2'b11};  // ADDW
                            default: rsvd = 1'b1;
                        endcase
                    end
                endcase
            end
            rvc_pkg::C_J:
                exp_c = {cj_off[11], cj_off[10:1], cj_off[11], {8{cj_off[11]}}, 5'd0,
                         rvc_pkg::JAL, 2'b11};
            rvc_pkg::C_BEQZ:
                exp_c = {{3{cb_off[8]}}, cb_off[8:5], 5'd0, rs1_p, 3'b000, cb_off[4:1],
                         cb_off[8], rvc_pkg::BRANCH, 2'b11};
            rvc_pkg::C_BNEZ:
                exp_c = {{3{cb_off[8]}}, cb_off[8:5], 5'd0, rs1_p, 3'b001, cb_off[4:1],
                         cb_off[8], rvc_pkg::BRANCH, 2'b11};
            rvc_pkg::C_SLLI:
                exp_c = {6'b000000, ci_imm, rd, 3'b001, rd, rvc_pkg::OP_IMM, 2'b11};
            rvc_pkg::C_LWSP: begin
                exp_c = {4'b0, lwsp_off, 5'd2, 3'b010, rd, rvc_pkg::LOAD, 2'b11};
                rsvd  = rd == '0;
            end
            rvc_pkg::C_LDSP: begin
                exp_c = {3'b0, ldsp_off, 5'd2, 3'b011, rd, rvc_pkg::LOAD, 2'b11};
                rsvd  = rd == '0;
            end
            rvc_pkg::C_JALR_MV_ADD: begin
                if (!c[12]) begin
                    if (rs2 == '0) begin
                        exp_c = {12'd0, rd, 3'b000, 5'd0, rvc_pkg::JALR, 2'b11};  // JR
                        rsvd  = rd == '0;
                    end else begin
                        exp_c = {7'd0, rs2, 5'd0, 3'b000, rd, rvc_pkg::OP, 2'b11};  // MV
                    end
                end else if (rs2 != '0) begin
                    exp_c = {7'd0, rs2, rd, 3'b000, rd, rvc_pkg::OP, 2'b11};  // ADD
                end else if (rd == '0) begin
                    exp_c = {12'd1, 5'd0, 3'b000, 5'd0, rvc_pkg::SYSTEM, 2'b11};  // EBREAK
                end else begin
                    exp_c = {12'd0, rd, 3'b000, 5'd1, rvc_pkg::JALR, 2'b11};
                end
            end
            rvc_pkg::C_SWSP:
                exp_c = {4'b0, swsp_off[7:5], rs2, 5'd2, 3'b010, swsp_off[4:0],
                         rvc_pkg::STORE, 2'b11};
            rvc_pkg::C_SDSP:
                exp_c = {3'b0, sdsp_off[8:5], rs2, 5'd2, 3'b011, sdsp_off[4:0],
                         rvc_pkg::STORE, 2'b11};
            default: rsvd = 1'b1;  // Reserved, FP load/store, quadrant 3
        endcase
    end

    assign illegal = is_rvc && rsvd;

    // Illegal words expand to zero
    always_comb begin
        if (!is_rvc) begin
            expanded = instruction;
        end else if (rsvd) begin
            expanded = '0;
        end else begin
            expanded = exp_c;
        end
    end

endmodule

// ==== source/rvc_front_top.sv ====
`timescale 1ns/1ps

module rvc_front_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,

    input  logic                 prev_stalled,
    output logic                 stall_prev,
    input  logic                 ifetch_exception,
    input  rvc_pkg::trap_cause_e ifetch_trap_cause,
    input  rvc_pkg::instr_t      instruction,
    input  rvc_pkg::addr_t       instruction_addr,
    input  rvc_pkg::addr_t       instruction_next_addr,

    input  logic                 out_stalled,
    output logic                 out_valid_n,
    output logic                 out_exception,
    output rvc_pkg::trap_cause_e out_trap_cause,
    output rvc_pkg::instr_t      out_original,
    output rvc_pkg::instr_t      out_expanded,
    output rvc_pkg::addr_t       out_addr,
    output rvc_pkg::addr_t       out_next_addr
);

    logic                    dec_stall_next;
    logic                    skid_stall_prev;
    rvc_pkg::decoded_entry_t dec_entry;
    rvc_pkg::decoded_entry_t out_entry;

    decode_decompress u_decomp (
        .clk                          (clk),
        .rst_n                        (rst_n),
        .flush                        (flush),
        .prev_stalled                 (prev_stalled),
        .next_stalled                 (skid_stall_prev),
        .stall_prev                   (stall_prev),
        .stall_next                   (dec_stall_next),
        .ifetch_exception             (ifetch_exception),
        .ifetch_trap_cause            (ifetch_trap_cause),
        .instruction                  (instruction),
        .instruction_addr             (instruction_addr),
        .instruction_next_addr        (instruction_next_addr),
        .decomp_exception             (dec_entry.exception),
        .decomp_trap_cause            (dec_entry.cause),
        .decomp_original_instruction  (dec_entry.original),
        .decomp_expanded_instruction  (dec_entry.expanded),
        .decomp_instruction_addr      (dec_entry.addr),
        .decomp_instruction_next_addr (dec_entry.next_addr)
    );

    skid_buffer #(
        .payload_t (rvc_pkg::decoded_entry_t)
    ) u_out_skid (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .prev_stalled (dec_stall_next),
        .next_stalled (out_stalled),
        .stall_prev   (skid_stall_prev),
        .stall_next   (out_valid_n),
        .in_data      (dec_entry),
        .out_data     (out_entry)
    );

    assign out_exception  = out_entry.exception;
    assign out_trap_cause = out_entry.cause;
    assign out_original   = out_entry.original;
    assign out_expanded   = out_entry.expanded;
    assign out_addr       = out_entry.addr;
    assign out_next_addr  = out_entry.next_addr;

endmodule

// ==== source/rvc_pkg.sv ====
`include "rvc_defines.svh"

package rvc_pkg;

    typedef logic [`RVC_ILEN-1:0] instr_t;
    typedef logic [`RVC_ALEN-1:0] addr_t;

    // Major opcodes, bits 6:2 of a 32-bit instruction
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        OP_IMM    = 5'b00100,
        OP_IMM_32 = 5'b00110,
        STORE     = 5'b01000,
        OP        = 5'b01100,
        LUI       = 5'b01101,
        OP_32     = 5'b01110,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011,
        SYSTEM    = 5'b11100
    } opcode_e;

    // {funct3, quadrant} of a 16-bit instruction
    typedef enum logic [4:0] {
        C_ADDI4SPN = 5'b000_00, C_FLD = 5'b001_00, C_LW = 5'b010_00, C_LD = 5'b011_00,
        C_RESERVED = 5'b100_00, C_FSD = 5'b101_00, C_SW = 5'b110_00, C_SD = 5'b111_00,
        C_ADDI = 5'b000_01, C_ADDIW = 5'b001_01, C_LI = 5'b010_01,
        C_LUI_ADDI16SP = 5'b011_01, C_MISC_ALU = 5'b100_01, C_J = 5'b101_01,
        C_BEQZ = 5'b110_01, C_BNEZ = 5'b111_01,
        C_SLLI = 5'b000_10, C_FLDSP = 5'b001_10, C_LWSP = 5'b010_10, C_LDSP = 5'b011_10,
        C_JALR_MV_ADD = 5'b100_10, C_FSDSP = 5'b101_10, C_SWSP = 5'b110_10,
        C_SDSP = 5'b111_10
    } c_op_e;

    typedef enum logic [3:0] {
        EXC_INSTR_MISALIGNED = 4'd0,
        EXC_INSTR_ACCESS     = 4'd1,
        EXC_ILLEGAL_INSTR    = 4'd2,
        EXC_INSTR_PAGE_FAULT = 4'd12
    } trap_cause_e;

    typedef struct packed {
        logic        exception;
        trap_cause_e cause;
        instr_t      instruction;
        addr_t       addr;
        addr_t       next_addr;
    } fetch_entry_t;

    typedef struct packed {
        logic        exception;
        trap_cause_e cause;
        instr_t      original;
        instr_t      expanded;
        addr_t       addr;
        addr_t       next_addr;
    } decoded_entry_t;

endpackage

// ==== source/skid_buffer.sv ====
`timescale 1ns/1ps

module skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,

    input  logic     prev_stalled,
    input  logic     next_stalled,
    output logic     stall_prev,
    output logic     stall_next,

    input  payload_t in_data,
    output payload_t out_data
);

    logic     full;
    payload_t held;

    // Captures the in-flight item when the consumer stalls
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            full <= 1'b0;
        end else if (full) begin
            full <= next_stalled;  // Drains once taken
        end else begin
            full <= !prev_stalled && next_stalled;
        end
    end

    always_ff @(posedge clk) begin
        if (!full) begin
            held <= in_data;
        end
    end

    assign stall_prev = full;

    // Nothing moves while a flush is in progress
    assign stall_next = flush || (!full && prev_stalled);

    assign out_data = full ? held : in_data;  // Zero latency when empty

endmodule
